// ==== design/adder_pkg.sv ====
package adder_pkg;

    // operand and tree geometry
    localparam int DATA_W = 64;
    localparam int HALF_W = DATA_W / 2;

    // request to response, in clock cycles
    localparam int PIPE_DEPTH = 4;

    // five spans per half: 1, 2, 4, 8, 16
    localparam int TREE_LEVELS = $clog2(HALF_W);

    // bit l set when level l+1 of the tree ends in a register
    localparam logic [TREE_LEVELS-1:0] TREE_REG_MASK = 5'b11010;

    // carry out of a bit or a group, for carry-in 1 and for carry-in 0
    // 00 kill, 10 propagate, 11 generate
    typedef struct packed {
        logic c1;
        logic c0;
    } carry_pair_t;

    typedef carry_pair_t [HALF_W-1:0] half_pairs_t;

    typedef struct packed {
        half_pairs_t hi;
        half_pairs_t lo;
    } split_pairs_t;

    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic              cin;
    } operand_t;

    typedef struct packed {
        logic     valid;
        operand_t op;
    } add_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] sum;
        logic              cout;
    } add_rsp_t;

endpackage

// ==== design/pipe_delay.sv ====
`timescale 1ns/10ps

module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = adder_pkg::PIPE_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    T stages [DEPTH];

    // shift chain of DEPTH stages
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                stages[i] <= '0;
            end
        end
        else
        begin
            stages[0] <= din;
            for (int i = 1; i < DEPTH; i++)
            begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

// ==== design/pgk_encode.sv ====
`timescale 1ns/10ps

module pgk_encode (
    input  logic                         clk,
    input  logic [adder_pkg::DATA_W-1:0] a,
    input  logic [adder_pkg::DATA_W-1:0] b,
    output adder_pkg::split_pairs_t      pairs
);

    adder_pkg::split_pairs_t pairs_d;

    // c0 is the carry out with carry-in 0, c1 with carry-in 1
    function automatic adder_pkg::carry_pair_t encode_bit(
        input logic a_bit,
        input logic b_bit
    );
        adder_pkg::carry_pair_t pair;
        pair.c0 = a_bit & b_bit;
        pair.c1 = a_bit | b_bit;
        return pair;
    endfunction

    always_comb
    begin
        for (int i = 0; i < adder_pkg::HALF_W; i++)
        begin
            pairs_d.lo[i] = encode_bit(a[i], b[i]);
            pairs_d.hi[i] = encode_bit(a[i + adder_pkg::HALF_W],
                                       b[i + adder_pkg::HALF_W]);
        end
    end

    // decode stage register
    always_ff @(posedge clk)
    begin
        pairs <= pairs_d;
    end

endmodule

// ==== design/prefix_tree.sv ====
`timescale 1ns/10ps

module prefix_tree (
    input  logic                   clk,
    input  adder_pkg::half_pairs_t pairs_in,
    output adder_pkg::half_pairs_t pairs_out
);

    // stage[l] feeds level l, stage[TREE_LEVELS] is the final group carry
    adder_pkg::half_pairs_t stage [adder_pkg::TREE_LEVELS+1];

    // group carry of own span given the carry out of the span below
    function automatic adder_pkg::carry_pair_t combine(
        input adder_pkg::carry_pair_t own,
        input adder_pkg::carry_pair_t low
    );
        adder_pkg::carry_pair_t grp;
        grp.c0 = own.c0 | (own.c1 & low.c0);
        grp.c1 = own.c0 | (own.c1 & low.c1);
        return grp;
    endfunction

    assign stage[0] = pairs_in;

    genvar l;
    generate
        for (l = 0; l < adder_pkg::TREE_LEVELS; l++)
        begin : g_level
            localparam int SPAN = 1 << l;

            adder_pkg::half_pairs_t comb_pairs;

            always_comb
            begin
                // positions below the span are already complete
                for (int i = 0; i < SPAN; i++)
                begin
                    comb_pairs[i] = stage[l][i];
                end
                for (int i = SPAN; i < adder_pkg::HALF_W; i++)
                begin
                    comb_pairs[i] = combine(stage[l][i], stage[l][i - SPAN]);
                end
            end

            if (adder_pkg::TREE_REG_MASK[l])
            begin : g_reg
                adder_pkg::half_pairs_t pairs_q;

                always_ff @(posedge clk)
                begin
                    pairs_q <= comb_pairs;
                end

                assign stage[l+1] = pairs_q;
            end
            else
            begin : g_comb
                assign stage[l+1] = comb_pairs;
            end
        end
    endgenerate

    // entry i covers bits 0 through i of this half
    assign pairs_out = stage[adder_pkg::TREE_LEVELS];

endmodule

// ==== design/sum_select.sv ====
`timescale 1ns/10ps

module sum_select (
    input  adder_pkg::half_pairs_t       lo_pairs,
    input  adder_pkg::half_pairs_t       hi_pairs,
    input  adder_pkg::operand_t          op,
    output logic [adder_pkg::DATA_W-1:0] sum,
    output logic                         cout
);

    localparam int HW = adder_pkg::HALF_W;

    // carry into each sum bit
    logic [adder_pkg::DATA_W-1:0] carries;
    logic                         mid_carry;

    // actual carry-in picks one of the two candidates
    function automatic logic pick(
        input adder_pkg::carry_pair_t pair,
        input logic                   carry_in
    );
        return carry_in ? pair.c1 : pair.c0;
    endfunction

    // carry out of the low half selects the high half
    assign mid_carry = pick(lo_pairs[HW-1], op.cin);

    always_comb
    begin
        carries[0] = op.cin;
        for (int i = 1; i < HW; i++)
        begin
            carries[i] = pick(lo_pairs[i-1], op.cin);
        end
        carries[HW] = mid_carry;
        for (int i = 1; i < HW; i++)
        begin
            carries[HW + i] = pick(hi_pairs[i-1], mid_carry);
        end
    end

    assign sum  = op.a ^ op.b ^ carries;
    assign cout = pick(hi_pairs[HW-1], mid_carry);

endmodule

// ==== design/adder64_pipe.sv ====
`timescale 1ns/10ps

module adder64_pipe (
    input  logic                clk,
    input  logic                rst,
    input  adder_pkg::add_req_t req,
    output adder_pkg::add_rsp_t rsp
);

    adder_pkg::split_pairs_t      pairs;
    adder_pkg::half_pairs_t       lo_grp;
    adder_pkg::half_pairs_t       hi_grp;
    adder_pkg::operand_t          op_d;
    logic                         valid_d;
    logic [adder_pkg::DATA_W-1:0] sum;
    logic                         cout;

    // decode, one cycle
    pgk_encode u_encode (
        .clk   (clk),
        .a     (req.op.a),
        .b     (req.op.b),
        .pairs (pairs)
    );

    // execute, three cycles per half
    prefix_tree u_tree_lo (
        .clk       (clk),
        .pairs_in  (pairs.lo),
        .pairs_out (lo_grp)
    );

    prefix_tree u_tree_hi (
        .clk       (clk),
        .pairs_in  (pairs.hi),
        .pairs_out (hi_grp)
    );

    // operands and valid line up with the tree output
    pipe_delay #(
        .T     (adder_pkg::operand_t),
        .DEPTH (adder_pkg::PIPE_DEPTH)
    ) u_op_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (req.op),
        .dout (op_d)
    );

    pipe_delay #(
        .T     (logic),
        .DEPTH (adder_pkg::PIPE_DEPTH)
    ) u_valid_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (req.valid),
        .dout (valid_d)
    );

    sum_select u_result (
        .lo_pairs (lo_grp),
        .hi_pairs (hi_grp),
        .op       (op_d),
        .sum      (sum),
        .cout     (cout)
    );

    always_comb
    begin
        rsp.valid = valid_d;
        rsp.sum   = sum;
        rsp.cout  = cout;
    end

endmodule

// ==== verif/adder64_chk.sv ====
`timescale 1ns/10ps

module adder64_chk (
    input logic                clk,
    input logic                rst,
    input adder_pkg::add_req_t req,
    input adder_pkg::add_rsp_t rsp
);

    int fail_count = 0;

    // each accepted request comes back after the fixed latency
    rsp_follows_req: assert property (
        @(posedge clk) disable iff (rst)
        req.valid |-> ##(adder_pkg::PIPE_DEPTH) rsp.valid
    )
    else
    begin
        fail_count++;
        $error("valid request got no response %0d cycles later", adder_pkg::PIPE_DEPTH);
    end

    // no response without a request behind it
    rsp_has_req: assert property (
        @(posedge clk) disable iff (rst)
        rsp.valid |-> $past(req.valid, adder_pkg::PIPE_DEPTH)
    )
    else
    begin
        fail_count++;
        $error("response without a request %0d cycles earlier", adder_pkg::PIPE_DEPTH);
    end

    // pipeline is flushed once reset has been seen at an edge
    quiet_in_reset: assert property (
        @(posedge clk)
        (rst && $past(rst)) |-> !rsp.valid
    )
    else
    begin
        fail_count++;
        $error("response valid while reset is held");
    end

endmodule

bind adder64_pipe adder64_chk u_chk (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
);

// ==== verif/tb_adder64.sv ====
`timescale 1ns/10ps

module tb_adder64;

    localparam int DW           = adder_pkg::DATA_W;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 4;
    localparam int N_TABLE      = 8;
    localparam int N_B2B        = 64;
    localparam int N_BUBBLE     = 24;
    localparam int MAX_GAP      = 3;
    localparam int STIM_CYCLES  = IDLE_CYCLES + N_TABLE + N_B2B + N_BUBBLE * (MAX_GAP + 1);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + adder_pkg::PIPE_DEPTH + 20;

    // one row of the corner case table
    typedef struct packed {
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        logic          cin;
        logic [DW-1:0] sum;
        logic          cout;
    } vec_t;

    logic                clk;
    logic                rst;
    adder_pkg::add_req_t req;
    adder_pkg::add_rsp_t rsp;

    vec_t  vectors [N_TABLE];
    string vec_names [N_TABLE];

    // requests in flight, oldest first
    string       test_q [$];
    string       label_q [$];
    logic [DW:0] exp_q [$];
    int          cyc_q [$];
    bit          last_q [$];

    logic [31:0] lfsr_state;
    int cycle        = 0;
    int err_count    = 0;
    int cur_errs     = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int req_count    = 0;
    int rsp_count    = 0;
    int assert_fails = 0;

    adder64_pipe uut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // reference sum over 65 bits
    function automatic logic [DW:0] model_add(
        input logic [DW-1:0] a,
        input logic [DW-1:0] b,
        input logic          cin
    );
        return {1'b0, a} + {1'b0, b} + {{DW{1'b0}}, cin};
    endfunction

    // galois form, shifts right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [DW-1:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val = {val[DW-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic compare(
        input string       name,
        input logic [DW:0] expected,
        input logic [DW:0] actual
    );
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            err_count++;
            cur_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (cur_errs == 0)
        begin
            $display("test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, cur_errs);
        end
        cur_errs = 0;
    endtask

    task automatic add_vector(
        input int            idx,
        input string         name,
        input logic [DW-1:0] a,
        input logic [DW-1:0] b,
        input logic          cin
    );
        logic [DW:0] total;
        total = model_add(a, b, cin);
        vec_names[idx]     = name;
        vectors[idx].a     = a;
        vectors[idx].b     = b;
        vectors[idx].cin   = cin;
        vectors[idx].sum   = total[DW-1:0];
        vectors[idx].cout  = total[DW];
    endtask

    task automatic load_vectors();
        add_vector(0, "zero_plus_zero", '0, '0, 1'b0);
        add_vector(1, "ones_plus_zero_cin", '1, '0, 1'b1);
        add_vector(2, "low_carry_into_high", 64'h0000_0000_ffff_ffff, 64'h1, 1'b0);
        add_vector(3, "high_ones_low_carry", 64'hffff_ffff_8000_0000,
                   64'h0000_0000_8000_0000, 1'b0);
        add_vector(4, "alternating_cin", 64'h5555_5555_5555_5555,
                   64'haaaa_aaaa_aaaa_aaaa, 1'b1);
        add_vector(5, "alternating_same", 64'h5555_5555_5555_5555,
                   64'h5555_5555_5555_5555, 1'b0);
        add_vector(6, "ones_plus_ones_cin", '1, '1, 1'b1);
        add_vector(7, "top_bits_overflow", 64'h8000_0000_0000_0000,
                   64'h8000_0000_0000_0000, 1'b0);
    endtask

    // drive until the next falling edge
    task automatic send(
        input string         test,
        input string         label,
        input logic [DW-1:0] a,
        input logic [DW-1:0] b,
        input logic          cin,
        input logic [DW:0]   expected,
        input bit            last
    );
        req.valid  = 1'b1;
        req.op.a   = a;
        req.op.b   = b;
        req.op.cin = cin;
        test_q.push_back(test);
        label_q.push_back(label);
        exp_q.push_back(expected);
        cyc_q.push_back(cycle);
        last_q.push_back(last);
        req_count++;
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    task automatic idle(input int n);
        req.valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic run_back_to_back();
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        logic [DW-1:0] c;
        for (int i = 0; i < N_B2B; i++)
        begin
            take_bits(DW, a);
            take_bits(DW, b);
            take_bits(1, c);
            send("back_to_back", $sformatf("back_to_back[%0d]", i), a, b, c[0],
                 model_add(a, b, c[0]), i == N_B2B - 1);
        end
    endtask

    task automatic run_bubbles();
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        logic [DW-1:0] c;
        logic [DW-1:0] gap;
        for (int i = 0; i < N_BUBBLE; i++)
        begin
            take_bits(DW, a);
            take_bits(DW, b);
            take_bits(1, c);
            send("bubbles", $sformatf("bubbles[%0d]", i), a, b, c[0],
                 model_add(a, b, c[0]), i == N_BUBBLE - 1);
            take_bits(2, gap);
            idle(int'(gap[1:0]));
        end
    endtask

    // response side sampled mid cycle
    always @(negedge clk)
    begin : check_response
        string       test;
        string       label;
        logic [DW:0] expected;
        int          sent;
        bit          last;
        if (rst)
        begin
            compare("reset_quiet", '0, {{DW{1'b0}}, rsp.valid});
        end
        else if (rsp.valid)
        begin
            rsp_count++;
            if (label_q.size() == 0)
            begin
                $display("unexpected response at cycle %0d, no request was in flight", cycle);
                err_count++;
                cur_errs++;
            end
            else
            begin
                test     = test_q.pop_front();
                label    = label_q.pop_front();
                expected = exp_q.pop_front();
                sent     = cyc_q.pop_front();
                last     = last_q.pop_front();
                compare(label, expected, {rsp.cout, rsp.sum});
                compare({label, " latency"}, (DW+1)'(adder_pkg::PIPE_DEPTH),
                        (DW+1)'(cycle - sent));
                if (last)
                begin
                    finish_test(test);
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles with responses still missing",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        req        = '0;
        rst        = 1'b1;
        lfsr_state = 32'd98;
        load_vectors();

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        idle(IDLE_CYCLES);
        finish_test("reset_quiet");

        for (int i = 0; i < N_TABLE; i++)
        begin
            send(vec_names[i], vec_names[i], vectors[i].a, vectors[i].b, vectors[i].cin,
                 {vectors[i].cout, vectors[i].sum}, 1'b1);
        end

        run_back_to_back();
        run_bubbles();

        // drain the pipeline and watch for strays
        while (label_q.size() != 0)
        begin
            @(negedge clk);
        end
        idle(IDLE_CYCLES);

        compare("response_count", (DW+1)'(req_count), (DW+1)'(rsp_count));
        finish_test("response_count");

        assert_fails = uut.u_chk.fail_count;
        $display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
design/adder_pkg.sv
design/pipe_delay.sv
design/pgk_encode.sv
design/prefix_tree.sv
design/sum_select.sv
design/adder64_pipe.sv
verif/adder64_chk.sv
verif/tb_adder64.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipelined adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_adder64 -f filelist.f
then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_adder64)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]
then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q -x "Simulation finished: PASS"
then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
